// File: hw/tmu_pkg.sv
/*
 * Shared types and register map of the TMU front end.
 * CSR addresses are word addresses: bits 13..10 pick the block, bits 4..0 the register.
 * The mesh memory holds 128 vertices per row, so a mesh is at most 128 x 128.
 */
`default_nettype none

package tmu_pkg;

	typedef logic [13:0] csr_addr_t;
	typedef logic [31:0] csr_data_t;

	typedef struct packed {
		csr_addr_t addr;
		logic      we;
		csr_data_t wdata;
	} csr_bus_t;

	typedef logic [6:0]  mesh_coord_t;  // Vertex index within a row or column
	typedef logic [29:0] mesh_addr_t;   // Address in 32-bit words
	typedef logic [10:0] res_t;

	typedef struct packed {
		mesh_coord_t hmesh_last;
		mesh_coord_t vmesh_last;
		mesh_addr_t  src_mesh;
		mesh_addr_t  dst_mesh;
	} walker_cfg_t;

	typedef struct packed {
		logic [5:0]  brightness;
		logic        chroma_key_en;
		logic [15:0] chroma_key;  // RGB565
		res_t        src_hres;
		res_t        src_vres;
		res_t        dst_hres;
		res_t        dst_vres;
	} raster_cfg_t;

	typedef struct packed {
		mesh_coord_t x;
		mesh_coord_t y;
		mesh_addr_t  src_addr;
		mesh_addr_t  dst_addr;
	} vertex_t;

	localparam int mesh_stride_log2 = 7;  // 128 vertices per mesh row

	typedef enum logic {
		st_idle,
		st_run
	} walker_state_t;

	// Register slots, 15 to 19 reserved
	localparam logic [4:0] reg_ctrl          = 5'd0;
	localparam logic [4:0] reg_hmesh_last    = 5'd1;
	localparam logic [4:0] reg_vmesh_last    = 5'd2;
	localparam logic [4:0] reg_brightness    = 5'd3;
	localparam logic [4:0] reg_chroma_key    = 5'd4;
	localparam logic [4:0] reg_src_mesh      = 5'd5;
	localparam logic [4:0] reg_src_fbuf      = 5'd6;
	localparam logic [4:0] reg_src_hres      = 5'd7;
	localparam logic [4:0] reg_src_vres      = 5'd8;
	localparam logic [4:0] reg_dst_mesh      = 5'd9;
	localparam logic [4:0] reg_dst_fbuf      = 5'd10;
	localparam logic [4:0] reg_dst_hres      = 5'd11;
	localparam logic [4:0] reg_dst_vres      = 5'd12;
	localparam logic [4:0] reg_perf_vertices = 5'd13;
	localparam logic [4:0] reg_perf_clocks   = 5'd14;

endpackage

`default_nettype wire

// File: hw/tmu_ctlif.sv
/*
 * CSR register file of the TMU.
 * Writes land at the edge where they are presented; reads return one cycle later.
 * Mesh bases keep bits 31..2 and framebuffer bases bits fml_depth-1..1 of the write data.
 * fml_depth must lie between 20 and 32. Unselected, reserved and unmapped slots read zero.
 * irq pulses for one cycle, two cycles after the last busy cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_ctlif
	import tmu_pkg::*;
#(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int fml_depth = 26
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  csr_bus_t             csr,
	output csr_data_t            csr_do,

	output logic                 irq,
	output logic                 start,
	input  logic                 busy,

	output walker_cfg_t          wcfg,
	output raster_cfg_t          rcfg,
	output logic [fml_depth-2:0] src_fbuf,  // In 16-bit words
	output logic [fml_depth-2:0] dst_fbuf,

	input  csr_data_t            perf_vertices,
	input  csr_data_t            perf_clocks
);

	logic       csr_selected;
	logic [4:0] csr_reg;
	logic       old_busy;

	assign csr_selected = csr.addr[13:10] == csr_addr;
	assign csr_reg = csr.addr[4:0];

	// End of run detection and start strobe
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			old_busy <= 1'b0;
			irq <= 1'b0;
			start <= 1'b0;
		end else begin
			old_busy <= busy;
			irq <= old_busy & ~busy;  // Falling edge of busy
			start <= csr_selected & csr.we & (csr_reg == reg_ctrl) & csr.wdata[0];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wcfg.hmesh_last <= 7'd32;
			wcfg.vmesh_last <= 7'd24;
			wcfg.src_mesh <= '0;
			wcfg.dst_mesh <= '0;
			rcfg.brightness <= 6'd63;
			rcfg.chroma_key_en <= 1'b0;
			rcfg.chroma_key <= 16'd0;
			rcfg.src_hres <= 11'd640;
			rcfg.src_vres <= 11'd480;
			rcfg.dst_hres <= 11'd640;
			rcfg.dst_vres <= 11'd480;
			src_fbuf <= '0;
			dst_fbuf <= '0;
		end else if (csr_selected && csr.we) begin
			case (csr_reg)
				reg_ctrl:       rcfg.chroma_key_en <= csr.wdata[1];
				reg_hmesh_last: wcfg.hmesh_last <= csr.wdata[6:0];
				reg_vmesh_last: wcfg.vmesh_last <= csr.wdata[6:0];
				reg_brightness: rcfg.brightness <= csr.wdata[5:0];
				reg_chroma_key: rcfg.chroma_key <= csr.wdata[15:0];
				reg_src_mesh:   wcfg.src_mesh <= csr.wdata[31:2];  // Byte to word address
				reg_src_fbuf:   src_fbuf <= csr.wdata[fml_depth-1:1];
				reg_src_hres:   rcfg.src_hres <= csr.wdata[10:0];
				reg_src_vres:   rcfg.src_vres <= csr.wdata[10:0];
				reg_dst_mesh:   wcfg.dst_mesh <= csr.wdata[31:2];
				reg_dst_fbuf:   dst_fbuf <= csr.wdata[fml_depth-1:1];
				reg_dst_hres:   rcfg.dst_hres <= csr.wdata[10:0];
				reg_dst_vres:   rcfg.dst_vres <= csr.wdata[10:0];
				default: ;  // Counters and reserved slots are read only
			endcase
		end
	end

	// Readback, realigned to byte addresses
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else if (!csr_selected) begin
			csr_do <= '0;
		end else begin
			case (csr_reg)
				reg_ctrl:          csr_do <= {30'd0, rcfg.chroma_key_en, busy};
				reg_hmesh_last:    csr_do <= csr_data_t'(wcfg.hmesh_last);
				reg_vmesh_last:    csr_do <= csr_data_t'(wcfg.vmesh_last);
				reg_brightness:    csr_do <= csr_data_t'(rcfg.brightness);
				reg_chroma_key:    csr_do <= csr_data_t'(rcfg.chroma_key);
				reg_src_mesh:      csr_do <= {wcfg.src_mesh, 2'b00};
				reg_src_fbuf:      csr_do <= csr_data_t'({src_fbuf, 1'b0});
				reg_src_hres:      csr_do <= csr_data_t'(rcfg.src_hres);
				reg_src_vres:      csr_do <= csr_data_t'(rcfg.src_vres);
				reg_dst_mesh:      csr_do <= {wcfg.dst_mesh, 2'b00};
				reg_dst_fbuf:      csr_do <= csr_data_t'({dst_fbuf, 1'b0});
				reg_dst_hres:      csr_do <= csr_data_t'(rcfg.dst_hres);
				reg_dst_vres:      csr_do <= csr_data_t'(rcfg.dst_vres);
				reg_perf_vertices: csr_do <= perf_vertices;
				reg_perf_clocks:   csr_do <= perf_clocks;
				default:           csr_do <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/tmu_mesh_walker.sv
/*
 * Mesh walker: visits every vertex in row-major order, one per cycle.
 * The configuration is captured on an accepted start; a start while busy is dropped.
 * No back-pressure, so vtx is only valid in the cycle of vtx_stb.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_mesh_walker
	import tmu_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic        start,
	input  walker_cfg_t wcfg,

	output logic        busy,
	output logic        vtx_stb,
	output vertex_t     vtx
);

	walker_state_t state;
	walker_cfg_t   cfg;  // Copy taken at start
	mesh_coord_t   x;
	mesh_coord_t   y;
	mesh_addr_t    offset;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (start) state <= st_run;
				st_run: if (x == cfg.hmesh_last && y == cfg.vmesh_last) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == st_idle) begin
			if (start) begin
				cfg <= wcfg;
				x <= '0;
				y <= '0;
			end
		end else if (x == cfg.hmesh_last) begin
			x <= '0;  // Next row
			y <= y + 7'd1;
		end else begin
			x <= x + 7'd1;
		end
	end

	// Word offset of the vertex within a mesh
	assign offset = (mesh_addr_t'(y) << mesh_stride_log2) | mesh_addr_t'(x);

	assign busy = state == st_run;
	assign vtx_stb = state == st_run;

	always_comb begin
		vtx.x = x;
		vtx.y = y;
		vtx.src_addr = cfg.src_mesh + offset;
		vtx.dst_addr = cfg.dst_mesh + offset;
	end

endmodule

`default_nettype wire

// File: hw/tmu_perf.sv
/*
 * Performance counters: vertices emitted and busy cycles of the last run.
 * Both clear on an accepted start and hold after the run. They wrap at 2^32.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_perf
	import tmu_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst,

	input  logic      start,
	input  logic      busy,
	input  logic      vtx_stb,

	output csr_data_t perf_vertices,
	output csr_data_t perf_clocks
);

	logic accepted;

	assign accepted = start & ~busy;  // Walker ignores start while busy

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			perf_vertices <= '0;
			perf_clocks <= '0;
		end else if (accepted) begin
			perf_vertices <= '0;
			perf_clocks <= '0;
		end else begin
			if (vtx_stb) perf_vertices <= perf_vertices + 32'd1;
			if (busy) perf_clocks <= perf_clocks + 32'd1;
		end
	end

endmodule

`default_nettype wire

// File: hw/tmu_top.sv
/*
 * TMU front end: CSR interface, mesh walker and performance counters.
 * Raster settings and framebuffer bases only leave through the ports.
 * csr_addr selects the CSR block; fml_depth must lie between 20 and 32.
 */
`timescale 1ns/1ps
`default_nettype none

module tmu_top
	import tmu_pkg::*;
#(
	parameter logic [3:0] csr_addr = 4'h0,
	parameter int fml_depth = 26
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst,

	input  csr_bus_t             csr,
	output csr_data_t            csr_do,
	output logic                 irq,

	output raster_cfg_t          rcfg,
	output logic [fml_depth-2:0] src_fbuf,
	output logic [fml_depth-2:0] dst_fbuf,

	output logic                 busy,
	output logic                 vtx_stb,
	output vertex_t              vtx
);

	logic        start;
	walker_cfg_t wcfg;
	csr_data_t   perf_vertices;
	csr_data_t   perf_clocks;

	tmu_ctlif #(
		.csr_addr(csr_addr),
		.fml_depth(fml_depth)
	) ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr(csr),
		.csr_do(csr_do),
		.irq(irq),
		.start(start),
		.busy(busy),
		.wcfg(wcfg),
		.rcfg(rcfg),
		.src_fbuf(src_fbuf),
		.dst_fbuf(dst_fbuf),
		.perf_vertices(perf_vertices),
		.perf_clocks(perf_clocks)
	);

	tmu_mesh_walker walker (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start(start),
		.wcfg(wcfg),
		.busy(busy),
		.vtx_stb(vtx_stb),
		.vtx(vtx)
	);

	tmu_perf perf (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start(start),
		.busy(busy),
		.vtx_stb(vtx_stb),
		.perf_vertices(perf_vertices),
		.perf_clocks(perf_clocks)
	);

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
/*
 * Clock and reset source for the testbench.
 * Reset is high from time zero and drops on the clock edge after rst_cycles edges.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int period = 4,     // In ns, even
	parameter int rst_cycles = 2
) (
	output logic sys_clk,
	output logic sys_rst
);

	initial begin
		sys_clk = 1'b0;
		forever #(period / 2) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst <= 1'b1;
		repeat (rst_cycles) @(posedge sys_clk);
		sys_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/tb_tmu.sv
/*
 * Directed testbench for the TMU front end with the CSR block at select 2.
 * Expected vertices come from the register values the testbench writes itself.
 * Inputs change on the rising edge, outputs are sampled on the falling edge.
 * A cycle limit ends the run if the DUT never signals completion.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tmu
	import tmu_pkg::*;
();

	localparam logic [3:0] blk = 4'd2;
	localparam int fml_depth = 26;
	localparam csr_data_t fbuf_mask = csr_data_t'((64'd1 << fml_depth) - 64'd2);
	localparam int max_vertices = 12;  // Largest mesh run
	localparam int num_runs = 7;
	localparam int csr_ops = 120;      // Upper bound on CSR accesses
	localparam int max_cycles = num_runs * (max_vertices + 12) + csr_ops * 3;

	logic                 sys_clk;
	logic                 sys_rst;
	csr_bus_t             csr;
	csr_data_t            csr_do;
	logic                 irq;
	raster_cfg_t          rcfg;
	logic [fml_depth-2:0] src_fbuf;
	logic [fml_depth-2:0] dst_fbuf;
	logic                 busy;
	logic                 vtx_stb;
	vertex_t              vtx;

	int          cyc = 0;
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	logic [31:0] rand_state = 32'd19;
	vertex_t     exp_q[$];  // Vertices still to come in this run
	int          run_len;
	int          stb_count;
	int          irq_count;
	int          first_stb_cyc;
	int          start_wr_cyc;
	int          busy_fall_cyc;
	int          irq_cyc;
	logic        prev_busy = 1'b0;
	int          cur_hl;
	int          cur_vl;
	csr_data_t   cur_src;
	csr_data_t   cur_dst;
	csr_data_t   rst_exp [15] = '{32'd0, 32'd32, 32'd24, 32'd63, 32'd0, 32'd0, 32'd0,
		32'd640, 32'd480, 32'd0, 32'd0, 32'd640, 32'd480, 32'd0, 32'd0};

	tb_clkgen #(.period(4), .rst_cycles(2)) clkgen (.sys_clk(sys_clk), .sys_rst(sys_rst));

	tmu_top #(.csr_addr(blk), .fml_depth(fml_depth)) DUT (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr(csr),
		.csr_do(csr_do),
		.irq(irq),
		.rcfg(rcfg),
		.src_fbuf(src_fbuf),
		.dst_fbuf(dst_fbuf),
		.busy(busy),
		.vtx_stb(vtx_stb),
		.vtx(vtx)
	);

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("Timeout: no completion within %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic csr_addr_t reg_addr(input logic [4:0] r);
		return {blk, 5'd0, r};
	endfunction

	// Readback after truncation and realignment to a byte address
	function automatic csr_data_t exp_readback(input logic [4:0] r, input csr_data_t d);
		case (r)
			reg_ctrl:                       return d & 32'h2;  // Only chroma_key_en as busy is low
			reg_hmesh_last, reg_vmesh_last: return d & 32'h7f;
			reg_brightness:                 return d & 32'h3f;
			reg_chroma_key:                 return d & 32'hffff;
			reg_src_mesh, reg_dst_mesh:     return d & 32'hffff_fffc;
			reg_src_fbuf, reg_dst_fbuf:     return d & fbuf_mask;
			default:                        return d & 32'h7ff;
		endcase
	endfunction

	task automatic expect_equal(input string name, input csr_data_t got, input csr_data_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic csr_write(input logic [4:0] r, input csr_data_t d);
		@(posedge sys_clk);
		csr <= '{addr: reg_addr(r), we: 1'b1, wdata: d};
		@(posedge sys_clk);
		csr <= '0;
	endtask

	task automatic csr_read(input csr_addr_t a, output csr_data_t d);
		@(posedge sys_clk);
		csr <= '{addr: a, we: 1'b0, wdata: 32'd0};
		@(posedge sys_clk);
		csr <= '0;
		@(negedge sys_clk);
		d = csr_do;
	endtask

	task automatic load_mesh(input int hl, input int vl,
		input csr_data_t src, input csr_data_t dst);
		cur_hl = hl;
		cur_vl = vl;
		cur_src = src;
		cur_dst = dst;
		csr_write(reg_hmesh_last, csr_data_t'(hl));
		csr_write(reg_vmesh_last, csr_data_t'(vl));
		csr_write(reg_src_mesh, src);
		csr_write(reg_dst_mesh, dst);
	endtask

	// Row-major reference walk of the current configuration
	task automatic queue_vertices();
		vertex_t v;
		exp_q.delete();
		for (int y = 0; y <= cur_vl; y++) begin
			for (int x = 0; x <= cur_hl; x++) begin
				v.x = mesh_coord_t'(x);
				v.y = mesh_coord_t'(y);
				v.src_addr = cur_src[31:2] + mesh_addr_t'(y * 128 + x);
				v.dst_addr = cur_dst[31:2] + mesh_addr_t'(y * 128 + x);
				exp_q.push_back(v);
			end
		end
		run_len = (cur_hl + 1) * (cur_vl + 1);
	endtask

	task automatic kick_run();
		stb_count = 0;
		irq_count = 0;
		first_stb_cyc = -1;
		busy_fall_cyc = -1;
		irq_cyc = -1;
		csr_write(reg_ctrl, 32'h1);
	endtask

	task automatic wait_done();
		while (irq_count == 0) @(posedge sys_clk);
		repeat (4) @(posedge sys_clk);  // Room for a stray second irq
		if (exp_q.size() != 0) begin
			$display("Run ended with %0d expected vertices missing", exp_q.size());
			errors++;
		end
		expect_equal("vtx_stb count", csr_data_t'(stb_count), csr_data_t'(run_len));
		expect_equal("first vtx_stb cycle", csr_data_t'(first_stb_cyc),
			csr_data_t'(start_wr_cyc + 2));
		expect_equal("busy fall cycle", csr_data_t'(busy_fall_cyc),
			csr_data_t'(first_stb_cyc + run_len));
		expect_equal("irq count", csr_data_t'(irq_count), 32'd1);
		expect_equal("irq cycle", csr_data_t'(irq_cyc), csr_data_t'(busy_fall_cyc + 1));
	endtask

	// Vertex checker and event recorder
	always @(negedge sys_clk) begin : monitor
		vertex_t ev;
		if (sys_rst === 1'b0) begin
			if (csr.we && csr.addr == reg_addr(reg_ctrl) && csr.wdata[0] && !busy)
				start_wr_cyc = cyc;
			if (prev_busy && !busy) busy_fall_cyc = cyc;
			if (irq) begin
				irq_count++;
				irq_cyc = cyc;
			end
			if (vtx_stb) begin
				if (stb_count == 0) first_stb_cyc = cyc;
				stb_count++;
				if (exp_q.size() == 0) begin
					$display("Vertex strobe at cycle %0d with no vertex expected", cyc);
					errors++;
				end else begin
					ev = exp_q.pop_front();
					if (vtx !== ev) begin
						$display("FAILED vtx: got 0x%h, expected 0x%h", vtx, ev);
						errors++;
					end
				end
			end
			prev_busy = busy;
		end
	end

	task automatic reset_values();
		int e0;
		csr_data_t d;
		e0 = errors;
		@(negedge sys_clk);
		expect_equal("busy", csr_data_t'(busy), 32'd0);
		expect_equal("vtx_stb", csr_data_t'(vtx_stb), 32'd0);
		expect_equal("irq", csr_data_t'(irq), 32'd0);
		expect_equal("csr_do", csr_do, 32'd0);
		for (int r = 0; r < 20; r++) begin
			csr_read(reg_addr(5'(r)), d);
			expect_equal($sformatf("reset slot %0d", r), d,
				(r < 15) ? rst_exp[r] : 32'd0);
		end
		csr_read(reg_addr(5'd31), d);
		expect_equal("unmapped slot", d, 32'd0);
		csr_read({4'd3, 5'd0, reg_src_hres}, d);
		expect_equal("other block", d, 32'd0);
		finish_test("reset values", e0);
	endtask

	task automatic reg_readback();
		int e0;
		csr_data_t d;
		csr_data_t wr [13];
		e0 = errors;
		for (int r = 0; r <= 12; r++) begin
			wr[r] = next_rand();
			if (r == 0) wr[r] = wr[r] & 32'hffff_fffe;  // No start
			csr_write(5'(r), wr[r]);
		end
		for (int r = 0; r <= 12; r++) begin
			csr_read(reg_addr(5'(r)), d);
			expect_equal($sformatf("register %0d", r), d, exp_readback(5'(r), wr[r]));
		end
		expect_equal("rcfg.brightness", csr_data_t'(rcfg.brightness), wr[3] & 32'h3f);
		expect_equal("rcfg.chroma_key_en", csr_data_t'(rcfg.chroma_key_en),
			(wr[0] >> 1) & 32'h1);
		expect_equal("rcfg.chroma_key", csr_data_t'(rcfg.chroma_key), wr[4] & 32'hffff);
		expect_equal("rcfg.src_hres", csr_data_t'(rcfg.src_hres), wr[7] & 32'h7ff);
		expect_equal("rcfg.src_vres", csr_data_t'(rcfg.src_vres), wr[8] & 32'h7ff);
		expect_equal("rcfg.dst_hres", csr_data_t'(rcfg.dst_hres), wr[11] & 32'h7ff);
		expect_equal("rcfg.dst_vres", csr_data_t'(rcfg.dst_vres), wr[12] & 32'h7ff);
		expect_equal("src_fbuf", csr_data_t'(src_fbuf), csr_data_t'(wr[6][fml_depth-1:1]));
		expect_equal("dst_fbuf", csr_data_t'(dst_fbuf), csr_data_t'(wr[10][fml_depth-1:1]));
		finish_test("register readback", e0);
	endtask

	task automatic mesh_walk();
		int e0;
		e0 = errors;
		load_mesh(2, 1, next_rand(), next_rand());
		queue_vertices();
		kick_run();
		wait_done();
		finish_test("mesh walk", e0);
	endtask

	task automatic run_completion();
		int e0;
		e0 = errors;
		load_mesh(0, 0, next_rand(), next_rand());  // Single vertex
		queue_vertices();
		kick_run();
		wait_done();
		load_mesh(3, 0, next_rand(), next_rand());
		queue_vertices();
		kick_run();
		wait_done();
		finish_test("completion", e0);
	endtask

	task automatic perf_counters();
		int e0;
		csr_data_t d;
		e0 = errors;
		load_mesh(3, 2, next_rand(), next_rand());
		queue_vertices();
		kick_run();
		while (!busy) @(negedge sys_clk);
		csr_write(reg_ctrl, 32'h1);  // Ignored while busy
		wait_done();
		csr_read(reg_addr(reg_perf_vertices), d);
		expect_equal("perf_vertices", d, csr_data_t'(run_len));
		csr_read(reg_addr(reg_perf_clocks), d);
		expect_equal("perf_clocks", d, csr_data_t'(run_len));
		load_mesh(1, 1, 32'd0, 32'd0);
		queue_vertices();
		kick_run();
		wait_done();
		csr_read(reg_addr(reg_perf_vertices), d);
		expect_equal("perf_vertices rerun", d, csr_data_t'(run_len));
		csr_read(reg_addr(reg_perf_clocks), d);
		expect_equal("perf_clocks rerun", d, csr_data_t'(run_len));
		finish_test("performance counters", e0);
	endtask

	task automatic cfg_latching();
		int e0;
		e0 = errors;
		load_mesh(4, 1, next_rand(), next_rand());
		queue_vertices();
		kick_run();
		while (!busy) @(negedge sys_clk);
		load_mesh(1, 2, next_rand(), next_rand());  // Lands during the run
		wait_done();
		queue_vertices();
		kick_run();
		wait_done();
		finish_test("configuration latching", e0);
	endtask

	initial begin
		csr <= '0;
		while (sys_rst !== 1'b0) @(posedge sys_clk);
		reset_values();
		reg_readback();
		mesh_walk();
		run_completion();
		perf_counters();
		cfg_latching();
		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
hw/tmu_pkg.sv
hw/tmu_ctlif.sv
hw/tmu_mesh_walker.sv
hw/tmu_perf.sv
hw/tmu_top.sv
sim/tb_clkgen.sv
sim/tb_tmu.sv

// File: run.sh
#!/bin/sh
# Build the TMU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_tmu -f tb.f -o sim_tmu

./obj_dir/sim_tmu > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
